// ==== source/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// ------------------------------------------------------------
// Cache geometry
// ------------------------------------------------------------

`define CACHE_LINES     16
`define CACHE_WORDS     8
`define CACHE_INDEX_W   4
`define CACHE_OFFSET_W  3

// 32 minus index, word offset and the 2 byte bits
`define CACHE_TAG_W     23

// ------------------------------------------------------------
// Memory port
// ------------------------------------------------------------

`define MEM_CREDITS     4

`endif

// ==== source/cache_pkg.sv ====
`include "cache_params.svh"

package cache_pkg;

  // Address split into its cache fields
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]    tag;
    logic [`CACHE_INDEX_W-1:0]  index;
    logic [`CACHE_OFFSET_W-1:0] offset;
    logic [1:0]                 byte_off;
  } cache_addr_fields_t;

  // Same 32 bits, seen either raw or decoded
  typedef union packed {
    logic [31:0]        raw;
    cache_addr_fields_t f;
  } cache_addr_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cache_op_t;

  typedef struct packed {
    cache_op_t   op;
    cache_addr_t addr;
    logic [31:0] data;
  } proc_req_t;

  // Write responses carry zero data
  typedef struct packed {
    cache_op_t   op;
    logic [31:0] data;
  } proc_resp_t;

  typedef struct packed {
    cache_op_t   op;
    cache_addr_t addr;
    logic [31:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] data;
  } mem_resp_t;

  typedef logic [`CACHE_WORDS-1:0][31:0] line_t;

endpackage

// ==== source/cache_tag_store.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_tag_store (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`CACHE_INDEX_W-1:0] index,
  input  logic [`CACHE_TAG_W-1:0]   req_tag,
  input  logic                      tag_wen,
  input  logic                      dirty_set,
  input  logic                      dirty_clr,
  output logic                      hit,
  output logic                      line_dirty,
  output logic [`CACHE_TAG_W-1:0]   stored_tag
);

  logic [`CACHE_TAG_W-1:0] tag_array [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] valid_bits;
  logic [`CACHE_LINES-1:0] dirty_bits;

  // ------------------------------------------------------------
  // Lookup
  // ------------------------------------------------------------

  assign stored_tag = tag_array[index];
  assign hit        = valid_bits[index] && (stored_tag == req_tag);

  // Only a valid line can need a write-back
  assign line_dirty = valid_bits[index] && dirty_bits[index];

  // ------------------------------------------------------------
  // Update
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (tag_wen) begin
      tag_array[index] <= req_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (tag_wen) begin
        // Freshly installed line matches memory
        valid_bits[index] <= 1'b1;
        dirty_bits[index] <= 1'b0;
      end else if (dirty_clr) begin
        dirty_bits[index] <= 1'b0;
      end else if (dirty_set) begin
        dirty_bits[index] <= 1'b1;
      end
    end
  end

endmodule

// ==== source/cache_line_store.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_line_store
  import cache_pkg::*;
(
  input  logic                       clk,
  input  logic [`CACHE_INDEX_W-1:0]  index,
  input  logic [`CACHE_OFFSET_W-1:0] word_sel,
  input  logic [`CACHE_OFFSET_W-1:0] read_sel,
  input  logic                       line_wen,
  input  logic                       word_wen,
  input  line_t                      fill_line,
  input  logic [31:0]                write_word,
  output logic [31:0]                read_word,
  output logic [31:0]                spill_word
);

  line_t data_array [`CACHE_LINES];

  logic [`CACHE_WORDS-1:0] word_en;
  line_t                   write_line;
  line_t                   cur_line;

  // ------------------------------------------------------------
  // Write path
  // ------------------------------------------------------------

  // Refill writes all words, a store hit only the addressed one
  always_comb begin
    word_en = '0;
    if (line_wen) begin
      word_en = '1;
    end else if (word_wen) begin
      word_en[word_sel] = 1'b1;
    end
  end

  // Store data replicated into every word slot
  always_comb begin
    if (line_wen) begin
      write_line = fill_line;
    end else begin
      write_line = {`CACHE_WORDS{write_word}};
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < `CACHE_WORDS; w++) begin
      if (word_en[w]) begin
        data_array[index][w] <= write_line[w];
      end
    end
  end

  // ------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------

  assign cur_line = data_array[index];

  // Processor read
  assign read_word = cur_line[word_sel];

  // Write-back walks the line with its own counter
  assign spill_word = cur_line[read_sel];

endmodule

// ==== source/cache_ctrl.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_ctrl
  import cache_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,

  input  logic                       proc_req_valid,
  input  proc_req_t                  proc_req,
  output logic                       proc_credit,
  output logic                       proc_resp_valid,
  output proc_resp_t                 proc_resp,

  output logic                       mem_req_valid,
  output mem_req_t                   mem_req,
  input  logic                       mem_credit,
  input  logic                       mem_resp_valid,
  input  mem_resp_t                  mem_resp,

  input  logic                       hit,
  input  logic                       line_dirty,
  input  logic [`CACHE_TAG_W-1:0]    stored_tag,
  input  logic [31:0]                read_word,
  input  logic [31:0]                spill_word,

  output logic [`CACHE_INDEX_W-1:0]  index,
  output logic [`CACHE_TAG_W-1:0]    req_tag,
  output logic [`CACHE_OFFSET_W-1:0] word_sel,
  output logic [`CACHE_OFFSET_W-1:0] read_sel,
  output logic                       tag_wen,
  output logic                       dirty_set,
  output logic                       dirty_clr,
  output logic                       line_wen,
  output logic                       word_wen,
  output line_t                      fill_line,
  output logic [31:0]                write_word
);

  localparam int CREDIT_W = $clog2(`MEM_CREDITS + 1);
  localparam logic [`CACHE_OFFSET_W-1:0] LAST_WORD = '1;
  localparam logic [`CACHE_OFFSET_W:0] ALL_WORDS = (`CACHE_OFFSET_W + 1)'(`CACHE_WORDS);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_SPILL,
    ST_REFILL_REQ,
    ST_REFILL_WAIT,
    ST_INSTALL,
    ST_RESPOND
  } state_t;

  state_t                     state;
  state_t                     state_next;
  proc_req_t                  req_q;
  proc_resp_t                 resp_q;
  logic [CREDIT_W-1:0]        credit_cnt;
  logic [`CACHE_OFFSET_W-1:0] spill_cnt;
  logic [`CACHE_OFFSET_W-1:0] refill_req_cnt;
  logic [`CACHE_OFFSET_W:0]   refill_resp_cnt;
  line_t                      refill_line;
  logic                       credit_init;
  logic                       mem_issue;
  logic                       store_hit;
  cache_addr_t                refill_addr;

  // ------------------------------------------------------------
  // Store controls
  // ------------------------------------------------------------

  assign index      = req_q.addr.f.index;
  assign req_tag    = req_q.addr.f.tag;
  assign word_sel   = req_q.addr.f.offset;
  assign read_sel   = spill_cnt;
  assign write_word = req_q.data;
  assign fill_line  = refill_line;

  assign store_hit = (state == ST_LOOKUP) && hit && (req_q.op == OP_WRITE);
  assign word_wen  = store_hit;
  assign dirty_set = store_hit;
  assign tag_wen   = (state == ST_INSTALL);
  assign line_wen  = (state == ST_INSTALL);

  // Old line is clean in memory once its last word is out
  assign dirty_clr = mem_issue && (state == ST_SPILL) && (spill_cnt == LAST_WORD);

  // ------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (proc_req_valid) state_next = ST_LOOKUP;
      end
      ST_LOOKUP: begin
        if (hit) state_next = ST_RESPOND;
        else if (line_dirty) state_next = ST_SPILL;
        else state_next = ST_REFILL_REQ;
      end
      ST_SPILL: begin
        if (mem_issue && spill_cnt == LAST_WORD) state_next = ST_REFILL_REQ;
      end
      ST_REFILL_REQ: begin
        if (mem_issue && refill_req_cnt == LAST_WORD) state_next = ST_REFILL_WAIT;
      end
      ST_REFILL_WAIT: begin
        if (refill_resp_cnt == ALL_WORDS) state_next = ST_INSTALL;
      end
      // Retry the lookup, which now hits
      ST_INSTALL: state_next = ST_LOOKUP;
      ST_RESPOND: state_next = ST_IDLE;
      default:    state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && proc_req_valid) begin
      req_q <= proc_req;
    end
  end

  // ------------------------------------------------------------
  // Processor response and credit
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (state == ST_LOOKUP && hit) begin
      resp_q.op   <= req_q.op;
      resp_q.data <= (req_q.op == OP_READ) ? read_word : 32'h0;
    end
  end

  assign proc_resp_valid = (state == ST_RESPOND);
  assign proc_resp       = resp_q;

  // One grant after reset, then one after every response
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_init <= 1'b0;
      proc_credit <= 1'b0;
    end else begin
      credit_init <= 1'b1;
      proc_credit <= proc_resp_valid || !credit_init;
    end
  end

  // ------------------------------------------------------------
  // Memory requests
  // ------------------------------------------------------------

  assign mem_req_valid = (state == ST_SPILL || state == ST_REFILL_REQ) && (credit_cnt != '0);
  assign mem_issue     = mem_req_valid;

  always_comb begin
    refill_addr            = req_q.addr;
    refill_addr.f.offset   = refill_req_cnt;
    refill_addr.f.byte_off = 2'b00;
  end

  always_comb begin
    mem_req = '0;
    if (state == ST_SPILL) begin
      mem_req.op           = OP_WRITE;
      mem_req.addr.f.tag   = stored_tag;
      mem_req.addr.f.index = req_q.addr.f.index;
      mem_req.addr.f.offset = spill_cnt;
      mem_req.data         = spill_word;
    end else begin
      mem_req.op   = OP_READ;
      mem_req.addr = refill_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      credit_cnt <= CREDIT_W'(`MEM_CREDITS);
    end else begin
      case ({mem_issue, mem_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // Word counters hold while credits are out
  always_ff @(posedge clk) begin
    if (reset) begin
      spill_cnt       <= '0;
      refill_req_cnt  <= '0;
      refill_resp_cnt <= '0;
    end else begin
      if (mem_issue && state == ST_SPILL) begin
        spill_cnt <= spill_cnt + 1'b1;
      end
      if (mem_issue && state == ST_REFILL_REQ) begin
        refill_req_cnt <= refill_req_cnt + 1'b1;
      end
      if (state == ST_INSTALL) begin
        refill_resp_cnt <= '0;
      end else if (mem_resp_valid) begin
        refill_resp_cnt <= refill_resp_cnt + 1'b1;
      end
    end
  end

  // Responses come back in order
  always_ff @(posedge clk) begin
    if (mem_resp_valid) begin
      refill_line[refill_resp_cnt[`CACHE_OFFSET_W-1:0]] <= mem_resp.data;
    end
  end

endmodule

// ==== source/cache_top.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_top
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  input  logic       proc_req_valid,
  input  proc_req_t  proc_req,
  output logic       proc_credit,
  output logic       proc_resp_valid,
  output proc_resp_t proc_resp,

  output logic       mem_req_valid,
  output mem_req_t   mem_req,
  input  logic       mem_credit,
  input  logic       mem_resp_valid,
  input  mem_resp_t  mem_resp
);

  logic [`CACHE_INDEX_W-1:0]  index;
  logic [`CACHE_TAG_W-1:0]    req_tag;
  logic [`CACHE_TAG_W-1:0]    stored_tag;
  logic [`CACHE_OFFSET_W-1:0] word_sel;
  logic [`CACHE_OFFSET_W-1:0] read_sel;
  logic                       hit;
  logic                       line_dirty;
  logic                       tag_wen;
  logic                       dirty_set;
  logic                       dirty_clr;
  logic                       line_wen;
  logic                       word_wen;
  line_t                      fill_line;
  logic [31:0]                write_word;
  logic [31:0]                read_word;
  logic [31:0]                spill_word;

  // ------------------------------------------------------------
  // Tags and data, both addressed by the registered request
  // ------------------------------------------------------------

  cache_tag_store cache_tag_store_inst (
    .clk        (clk),
    .reset      (reset),
    .index      (index),
    .req_tag    (req_tag),
    .tag_wen    (tag_wen),
    .dirty_set  (dirty_set),
    .dirty_clr  (dirty_clr),
    .hit        (hit),
    .line_dirty (line_dirty),
    .stored_tag (stored_tag)
  );

  cache_line_store cache_line_store_inst (
    .clk        (clk),
    .index      (index),
    .word_sel   (word_sel),
    .read_sel   (read_sel),
    .line_wen   (line_wen),
    .word_wen   (word_wen),
    .fill_line  (fill_line),
    .write_word (write_word),
    .read_word  (read_word),
    .spill_word (spill_word)
  );

  cache_ctrl cache_ctrl_inst (
    .clk             (clk),
    .reset           (reset),
    .proc_req_valid  (proc_req_valid),
    .proc_req        (proc_req),
    .proc_credit     (proc_credit),
    .proc_resp_valid (proc_resp_valid),
    .proc_resp       (proc_resp),
    .mem_req_valid   (mem_req_valid),
    .mem_req         (mem_req),
    .mem_credit      (mem_credit),
    .mem_resp_valid  (mem_resp_valid),
    .mem_resp        (mem_resp),
    .hit             (hit),
    .line_dirty      (line_dirty),
    .stored_tag      (stored_tag),
    .read_word       (read_word),
    .spill_word      (spill_word),
    .index           (index),
    .req_tag         (req_tag),
    .word_sel        (word_sel),
    .read_sel        (read_sel),
    .tag_wen         (tag_wen),
    .dirty_set       (dirty_set),
    .dirty_clr       (dirty_clr),
    .line_wen        (line_wen),
    .word_wen        (word_wen),
    .fill_line       (fill_line),
    .write_word      (write_word)
  );

endmodule

// ==== tb/cache_tb.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_tb
  import cache_pkg::*;
();

  localparam int GOLDEN_MAX = 64;

  logic       clk = 1'b0;
  logic       reset;
  logic       proc_req_valid;
  proc_req_t  proc_req;
  logic       proc_credit;
  logic       proc_resp_valid;
  proc_resp_t proc_resp;
  logic       mem_req_valid;
  mem_req_t   mem_req;
  logic       mem_credit = 1'b0;
  logic       mem_resp_valid = 1'b0;
  mem_resp_t  mem_resp = '0;

  logic [31:0]             golden [GOLDEN_MAX*4];
  logic [31:0]             mem_model [logic [31:0]];
  logic [31:0]             shadow [logic [31:0]];
  logic [`CACHE_TAG_W-1:0] m_tag [`CACHE_LINES];
  logic                    m_valid [`CACHE_LINES];
  logic                    m_dirty [`CACHE_LINES];
  mem_req_t                got_mem_q [$];
  int                      credit_due_q [$];
  int                      resp_due_q [$];
  logic [31:0]             resp_data_q [$];
  proc_resp_t              last_resp;

  int cycle_count = 0;
  int timeout_limit = 0;
  int num_ops = 0;
  int error_count = 0;
  int mem_errors = 0;
  int tests_failed = 0;
  int resp_count = 0;
  int credit_seen = 0;
  int resp_cycle = 0;
  int mem_issued = 0;
  int outstanding = 0;
  int last_credit_due = 0;

  cache_top cache_top_inst (
    .clk             (clk),
    .reset           (reset),
    .proc_req_valid  (proc_req_valid),
    .proc_req        (proc_req),
    .proc_credit     (proc_credit),
    .proc_resp_valid (proc_resp_valid),
    .proc_resp       (proc_resp),
    .mem_req_valid   (mem_req_valid),
    .mem_req         (mem_req),
    .mem_credit      (mem_credit),
    .mem_resp_valid  (mem_resp_valid),
    .mem_resp        (mem_resp)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("Timeout after %0d cycles, the run did not complete", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] init_word(input logic [31:0] a);
    return a ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [31:0] mem_value(input logic [31:0] a);
    return mem_model.exists(a) ? mem_model[a] : init_word(a);
  endfunction

  function automatic logic [31:0] shadow_value(input logic [31:0] a);
    return shadow.exists(a) ? shadow[a] : init_word(a);
  endfunction

  function automatic int total_errors();
    return error_count + mem_errors;
  endfunction

  // ------------------------------------------------------------
  // Processor side monitor
  // ------------------------------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      if (proc_resp_valid) begin
        resp_count <= resp_count + 1;
        resp_cycle <= cycle_count;
        last_resp  <= proc_resp;
      end
      if (proc_credit) begin
        credit_seen <= credit_seen + 1;
      end
    end
  end

  // ------------------------------------------------------------
  // Memory model with random credit and response delay
  // ------------------------------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      if (mem_credit) begin
        outstanding--;
      end
      if (mem_req_valid) begin
        mem_issued++;
        outstanding++;
        if (outstanding > `MEM_CREDITS) begin
          $display("Memory requests outstanding rose to %0d, above the credit limit", outstanding);
          mem_errors++;
        end
        got_mem_q.push_back(mem_req);
        // Credits return in order, each 0 to 3 cycles after the one before
        last_credit_due = ((last_credit_due < cycle_count) ? cycle_count : last_credit_due + 1)
                          + int'($urandom % 4);
        credit_due_q.push_back(last_credit_due);
        if (mem_req.op == OP_WRITE) begin
          mem_model[{mem_req.addr.raw[31:2], 2'b00}] = mem_req.data;
        end else begin
          resp_due_q.push_back(cycle_count + 1 + int'($urandom % 4));
          resp_data_q.push_back(mem_value({mem_req.addr.raw[31:2], 2'b00}));
        end
      end
      // At most one credit and one response per cycle
      if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle_count) begin
        mem_credit <= 1'b1;
        void'(credit_due_q.pop_front());
      end else begin
        mem_credit <= 1'b0;
      end
      if (resp_due_q.size() > 0 && resp_due_q[0] <= cycle_count) begin
        mem_resp_valid <= 1'b1;
        mem_resp.data  <= resp_data_q.pop_front();
        void'(resp_due_q.pop_front());
      end else begin
        mem_resp_valid <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------

  task automatic check_proc_resp(input proc_resp_t exp, input proc_resp_t got);
    if (got !== exp) begin
      $display("** Error proc_resp: expected %h, got %h", exp, got);
      error_count++;
    end
  endtask

  // Read requests carry no data worth comparing
  task automatic check_mem_req(input int k, input mem_req_t exp, input mem_req_t got);
    logic data_bad;
    data_bad = (exp.op == OP_WRITE) && (got.data !== exp.data);
    if (got.op !== exp.op || got.addr !== exp.addr || data_bad) begin
      $display("** Error mem_req[%0d]: expected %h, got %h", k, exp, got);
      error_count++;
    end
  endtask

  task automatic run_op(input int i);
    proc_req_t                 req;
    proc_resp_t                exp_resp;
    mem_req_t                  exp_q [$];
    mem_req_t                  e;
    cache_addr_t               a;
    logic [`CACHE_INDEX_W-1:0] idx;
    logic                      model_hit;
    int                        req_cycle;
    int                        errs_before;
    int                        resp_before;
    int                        credit_before;

    errs_before   = total_errors();
    req.op        = cache_op_t'(golden[4*i][0]);
    req.addr.raw  = golden[4*i+1];
    req.data      = golden[4*i+2];
    exp_resp.op   = req.op;
    exp_resp.data = (req.op == OP_READ) ? golden[4*i+3] : 32'h0;

    // Tag model predicts the write-back and refill traffic
    idx       = req.addr.f.index;
    model_hit = m_valid[idx] && (m_tag[idx] == req.addr.f.tag);
    if (!model_hit) begin
      if (m_valid[idx] && m_dirty[idx]) begin
        for (int w = 0; w < `CACHE_WORDS; w++) begin
          a.raw      = '0;
          a.f.tag    = m_tag[idx];
          a.f.index  = idx;
          a.f.offset = w[`CACHE_OFFSET_W-1:0];
          e.op       = OP_WRITE;
          e.addr     = a;
          e.data     = shadow_value(a.raw);
          exp_q.push_back(e);
        end
      end
      for (int w = 0; w < `CACHE_WORDS; w++) begin
        a            = req.addr;
        a.f.offset   = w[`CACHE_OFFSET_W-1:0];
        a.f.byte_off = 2'b00;
        e.op         = OP_READ;
        e.addr       = a;
        e.data       = 32'h0;
        exp_q.push_back(e);
      end
      m_valid[idx] = 1'b1;
      m_tag[idx]   = req.addr.f.tag;
      m_dirty[idx] = 1'b0;
    end
    if (req.op == OP_WRITE) begin
      shadow[{req.addr.raw[31:2], 2'b00}] = req.data;
      m_dirty[idx] = 1'b1;
    end

    got_mem_q.delete();
    resp_before    = resp_count;
    credit_before  = credit_seen;
    proc_req_valid <= 1'b1;
    proc_req       <= req;
    @(posedge clk);
    proc_req_valid <= 1'b0;
    req_cycle = cycle_count;
    while (resp_count == resp_before) begin
      @(posedge clk);
    end
    while (credit_seen == credit_before) begin
      @(posedge clk);
    end

    check_proc_resp(exp_resp, last_resp);
    if (model_hit && (resp_cycle - req_cycle != 2)) begin
      $display("Hit answered after %0d cycles instead of 2", resp_cycle - req_cycle);
      error_count++;
    end
    if (got_mem_q.size() != exp_q.size()) begin
      $display("Op %0d sent %0d memory requests where %0d were due", i, got_mem_q.size(),
               exp_q.size());
      error_count++;
    end else begin
      foreach (exp_q[k]) begin
        check_mem_req(k, exp_q[k], got_mem_q[k]);
      end
    end
    if (resp_count != i + 1 || credit_seen != i + 2) begin
      $display("Op %0d saw %0d responses and %0d credits in total", i, resp_count, credit_seen);
      error_count++;
    end

    if (total_errors() == errs_before) begin
      $display("Op %0d %s %h %s: ok", i, (req.op == OP_READ) ? "read " : "write",
               req.addr.raw, model_hit ? "hit " : "miss");
    end else begin
      tests_failed++;
      $display("Op %0d %s %h: FAILED", i, (req.op == OP_READ) ? "read " : "write",
               req.addr.raw);
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    void'($urandom(85));
    reset          = 1'b1;
    proc_req_valid = 1'b0;
    proc_req       = '0;
    for (int k = 0; k < GOLDEN_MAX * 4; k++) begin
      golden[k] = '1;
    end
    for (int k = 0; k < `CACHE_LINES; k++) begin
      m_valid[k] = 1'b0;
      m_dirty[k] = 1'b0;
      m_tag[k]   = '0;
    end
    $readmemh("tb/cache_golden.txt", golden);
    while (num_ops < GOLDEN_MAX && golden[4*num_ops] != 32'hffff_ffff) begin
      num_ops++;
    end
    timeout_limit = num_ops * 200;
    if (num_ops == 0) begin
      $display("The golden file holds no operations");
      error_count++;
      timeout_limit = 200;
    end

    repeat (8) @(posedge clk);
    reset <= 1'b0;
    while (credit_seen == 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    // Exactly one grant and no traffic out of reset
    if (credit_seen != 1 || resp_count != 0 || mem_issued != 0) begin
      $display("Reset check: %0d credits, %0d responses, %0d memory requests",
               credit_seen, resp_count, mem_issued);
      error_count++;
      tests_failed++;
      $display("Reset check: FAILED");
    end else begin
      $display("Reset check: ok");
    end

    for (int i = 0; i < num_ops; i++) begin
      run_op(i);
    end

    repeat (10) @(posedge clk);
    if (resp_count != num_ops || credit_seen != num_ops + 1) begin
      $display("Extra responses or credits arrived after the last operation");
      error_count++;
    end
    $display("Tests: %0d, failed: %0d, errors: %0d", num_ops + 1, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+source
source/cache_pkg.sv
source/cache_tag_store.sv
source/cache_line_store.sv
source/cache_ctrl.sv
source/cache_top.sv
tb/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module cache_tb -f list.f -o cache_sim

./obj_dir/cache_sim > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without failure"

// ==== tb/cache_golden.txt ====
// Columns are op (0 read, 1 write), address, write data and expected read data in hex
// Memory starts as address xor 5a5a0000
// Read miss on a clean line, then hits and a store hit
0 00000104 00000000 5a5a0104
0 00000110 00000000 5a5a0110
1 00000108 cafe0001 00000000
0 00000108 00000000 cafe0001
0 0000011c 00000000 5a5a011c
// Conflict on dirty line 8, then the old word from memory
0 00000304 00000000 5a5a0304
0 00000108 00000000 cafe0001
// Write allocate on line 2, write-back by another tag
1 00000040 12345678 00000000
1 0000005c 0badf00d 00000000
0 00001040 00000000 5a5a1040
0 0000005c 00000000 0badf00d
0 00000044 00000000 5a5a0044
1 00000304 a5a5a5a5 00000000
0 00000304 00000000 a5a5a5a5
// Line 15
0 000003e0 00000000 5a5a03e0
1 000003e4 00c0ffee 00000000
0 0000ffe4 00000000 5a5affe4
0 000003e4 00000000 00c0ffee
// Line 8 dirty again with tag 1
0 00000108 00000000 cafe0001
0 00000304 00000000 a5a5a5a5
// High addresses on line 0
1 80000000 deadbeef 00000000
0 80000000 00000000 deadbeef
0 80000004 00000000 da5a0004
0 00000040 00000000 12345678
